/* include/st7735_init_table.svh */
/*
 * ST7735R power-up configuration table, rs flag and byte per entry
 */
`ifndef ST7735_INIT_TABLE_SVH
`define ST7735_INIT_TABLE_SVH

localparam init_entry_t INIT_TABLE [INIT_LEN] = '{
    '{1'b0, 8'h11},                                                   // sleep out
    '{1'b0, 8'hb1}, '{1'b1, 8'h01}, '{1'b1, 8'h2c}, '{1'b1, 8'h2d},   // frame rate, normal
    '{1'b0, 8'hb2}, '{1'b1, 8'h01}, '{1'b1, 8'h2c}, '{1'b1, 8'h2d},   // frame rate, idle
    '{1'b0, 8'hb3}, '{1'b1, 8'h01}, '{1'b1, 8'h2c}, '{1'b1, 8'h2d},   // frame rate, partial
    '{1'b1, 8'h01}, '{1'b1, 8'h2c}, '{1'b1, 8'h2d},
    '{1'b0, 8'hb4}, '{1'b1, 8'h03},                                   // column inversion
    '{1'b0, 8'hb6}, '{1'b1, 8'hb4}, '{1'b1, 8'hf0},
    '{1'b0, 8'hc0}, '{1'b1, 8'ha2}, '{1'b1, 8'h02}, '{1'b1, 8'h84},   // power control
    '{1'b0, 8'hc1}, '{1'b1, 8'hc5},
    '{1'b0, 8'hc2}, '{1'b1, 8'h0a}, '{1'b1, 8'h00},
    '{1'b0, 8'hc3}, '{1'b1, 8'h8a}, '{1'b1, 8'h2a},
    '{1'b0, 8'hc4}, '{1'b1, 8'h8a}, '{1'b1, 8'hee},
    '{1'b0, 8'hc5}, '{1'b1, 8'h0a},                                   // vcom
    '{1'b0, 8'h36}, '{1'b1, 8'hc8},                                   // scan direction
    '{1'b0, 8'he0}, '{1'b1, 8'h02}, '{1'b1, 8'h1c}, '{1'b1, 8'h07},   // positive gamma
    '{1'b1, 8'h12}, '{1'b1, 8'h37}, '{1'b1, 8'h32}, '{1'b1, 8'h29},
    '{1'b1, 8'h2d}, '{1'b1, 8'h29}, '{1'b1, 8'h25}, '{1'b1, 8'h2b},
    '{1'b1, 8'h39}, '{1'b1, 8'h00}, '{1'b1, 8'h01}, '{1'b1, 8'h03}, '{1'b1, 8'h10},
    '{1'b0, 8'he1}, '{1'b1, 8'h03}, '{1'b1, 8'h1d}, '{1'b1, 8'h07},   // negative gamma
    '{1'b1, 8'h06}, '{1'b1, 8'h2e}, '{1'b1, 8'h2c}, '{1'b1, 8'h29},
    '{1'b1, 8'h2d}, '{1'b1, 8'h2e}, '{1'b1, 8'h2e}, '{1'b1, 8'h37},
    '{1'b1, 8'h3f}, '{1'b1, 8'h00}, '{1'b1, 8'h00}, '{1'b1, 8'h02}, '{1'b1, 8'h10},
    '{1'b0, 8'h2a}, '{1'b1, 8'h00}, '{1'b1, 8'h00}, '{1'b1, 8'h00}, '{1'b1, 8'h7f},  // columns
    '{1'b0, 8'h2b}, '{1'b1, 8'h00}, '{1'b1, 8'h00}, '{1'b1, 8'h00}, '{1'b1, 8'h9f},  // rows
    '{1'b0, 8'hf0}, '{1'b1, 8'h01},                                   // test command on
    '{1'b0, 8'hf6}, '{1'b1, 8'h00},                                   // ram power save off
    '{1'b0, 8'h3a}, '{1'b1, 8'h05},                                   // 65k colour mode
    '{1'b0, 8'h29}                                                    // display on
};

`endif

/* rtl/st7735_pkg.sv */
/*
 * shared constants and types for the ST7735R fill design
 * command codes, colour bands, table size and counter widths
 */
package st7735_pkg;

    // ==================================================
    // table and frame sizes
    // ==================================================

    localparam int INIT_LEN  = 91;  // sleep-out, config bytes, display-on
    localparam int NUM_BANDS = 5;   // colour bands per frame

    // width of the power sequencer delay counter
    // a delay of up to 2**DLY_W cycles fits
    localparam int DLY_W = 16;

    // ==================================================
    // command codes
    // ==================================================

    localparam logic [7:0] CMD_RAMWR = 8'h2c;  // memory write

    // ==================================================
    // types
    // ==================================================

    typedef logic [15:0] word_t;      // 8-bit words sit in the low byte
    typedef logic [6:0]  table_idx_t; // 0 .. INIT_LEN-1
    typedef logic [2:0]  band_idx_t;  // 0 .. NUM_BANDS-1

    // one configuration table entry
    typedef struct packed {
        logic       rs;    // 1 data, 0 command
        logic [7:0] data;
    } init_entry_t;

    // ==================================================
    // colour bands, RGB565
    // ==================================================

    localparam word_t band_color [NUM_BANDS] = '{
        16'hf800,  // red
        16'hffff,  // white
        16'h07e0,  // green
        16'h0000,  // black
        16'h001f   // blue
    };

endpackage

/* rtl/lcd_word_if.sv */
/*
 * word hand-off from the command source to the serial shifter
 */
`timescale 1ns/1ns

interface lcd_word_if;

    import st7735_pkg::*;

    logic  load;  // one-cycle strobe, shifter idle
    word_t word;  // payload, low byte for 8-bit words
    logic  rs;    // 1 data, 0 command
    logic  wide;  // 1 for a 16-bit pixel word
    logic  done;  // pulses in the last bit cycle

    modport src (
        output load, word, rs, wide,
        input  done
    );

    modport shf (
        input  load, word, rs, wide,
        output done
    );

endinterface

/* rtl/lcd_phase_if.sv */
/*
 * phase pulses between the power sequencer and the command source
 */
`timescale 1ns/1ns

interface lcd_phase_if;

    // all five are single-cycle pulses
    logic boot_go;       // send sleep-out
    logic slpout_sent;   // sleep-out word shifted
    logic config_go;     // send entries 1 .. 90
    logic disp_on_sent;  // display-on word shifted
    logic fill_go;       // send memory write and pixels

    modport seq (
        output boot_go, config_go, fill_go,
        input  slpout_sent, disp_on_sent
    );

    modport src (
        input  boot_go, config_go, fill_go,
        output slpout_sent, disp_on_sent
    );

endinterface

/* rtl/panel_power_seq.sv */
/*
 * panel reset pulse and power-up wait phases
 * one phase register and one reloading down-counter
 */
`timescale 1ns/1ns

module panel_power_seq #(
    parameter int RST_LEAD_CYCLES    = 4096,
    parameter int RST_LOW_CYCLES     = 4096,
    parameter int RST_RECOVER_CYCLES = 4096,
    parameter int SLEEP_WAIT_CYCLES  = 65535,
    parameter int DISP_WAIT_CYCLES   = 65535
) (
    input  logic     lcd_clk,
    input  logic     sys_rst_n,
    output logic     lcd_rst,
    lcd_phase_if.seq phase
);

    import st7735_pkg::*;

    typedef enum logic [2:0] {
        PH_LEAD,         // rst high after power-on
        PH_LOW,          // rst pulse
        PH_RECOVER,      // wait before the first command
        PH_WAIT_BOOT,    // sleep-out being sent
        PH_SLEEP_WAIT,   // panel wakes up
        PH_WAIT_CONFIG,  // config table being sent
        PH_DISP_WAIT,    // display turns on
        PH_RUN           // pixels flowing or frame done
    } phase_t;

    phase_t           cur_phase;
    logic [DLY_W-1:0] dly_cnt;
    logic             dly_zero;

    assign dly_zero = (dly_cnt == '0);

    // ==================================================
    // phase register and delay counter
    // ==================================================

    always_ff @(posedge lcd_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            cur_phase       <= PH_LEAD;
            dly_cnt         <= DLY_W'(RST_LEAD_CYCLES - 1);
            lcd_rst         <= 1'b1;
            phase.boot_go   <= 1'b0;
            phase.config_go <= 1'b0;
            phase.fill_go   <= 1'b0;
        end else begin
            phase.boot_go   <= 1'b0;
            phase.config_go <= 1'b0;
            phase.fill_go   <= 1'b0;
            if (!dly_zero) begin
                dly_cnt <= dly_cnt - 1'b1;  // reloads below override
            end
            case (cur_phase)
                PH_LEAD: if (dly_zero) begin
                    cur_phase <= PH_LOW;
                    dly_cnt   <= DLY_W'(RST_LOW_CYCLES - 1);
                    lcd_rst   <= 1'b0;
                end
                PH_LOW: if (dly_zero) begin
                    cur_phase <= PH_RECOVER;
                    dly_cnt   <= DLY_W'(RST_RECOVER_CYCLES - 1);
                    lcd_rst   <= 1'b1;
                end
                PH_RECOVER: if (dly_zero) begin
                    cur_phase     <= PH_WAIT_BOOT;
                    phase.boot_go <= 1'b1;
                end
                PH_WAIT_BOOT: if (phase.slpout_sent) begin
                    cur_phase <= PH_SLEEP_WAIT;
                    dly_cnt   <= DLY_W'(SLEEP_WAIT_CYCLES - 1);
                end
                PH_SLEEP_WAIT: if (dly_zero) begin
                    cur_phase       <= PH_WAIT_CONFIG;
                    phase.config_go <= 1'b1;
                end
                PH_WAIT_CONFIG: if (phase.disp_on_sent) begin
                    cur_phase <= PH_DISP_WAIT;
                    dly_cnt   <= DLY_W'(DISP_WAIT_CYCLES - 1);
                end
                PH_DISP_WAIT: if (dly_zero) begin
                    cur_phase     <= PH_RUN;
                    phase.fill_go <= 1'b1;
                end
                default: ;  // run stays until reset
            endcase
        end
    end

    // the command source must not report sleep-out outside its own phase
    a_slpout_in_wait: assert property (
        @(posedge lcd_clk) disable iff (!sys_rst_n)
        phase.slpout_sent |-> cur_phase == PH_WAIT_BOOT
    );

endmodule

/* rtl/st7735_cmd_source.sv */
/*
 * command and pixel word source for the ST7735R
 * config table, memory-write command, then five colour bands
 */
`timescale 1ns/1ns

module st7735_cmd_source #(
    parameter int PIXELS_PER_BAND = 4096
) (
    input  logic     lcd_clk,
    input  logic     sys_rst_n,
    lcd_phase_if.src phase,
    lcd_word_if.src  word_bus
);

    import st7735_pkg::*;

    `include "st7735_init_table.svh"

    localparam int PIX_W = (PIXELS_PER_BAND > 1) ? $clog2(PIXELS_PER_BAND) : 1;

    typedef enum logic [2:0] {
        ST_IDLE,    // waiting for a go pulse
        ST_BOOT,    // sleep-out on the wire
        ST_CONFIG,  // table entries 1 .. 90
        ST_RAMWR,   // memory-write command
        ST_PIXELS,  // colour bands
        ST_DONE     // frame complete
    } src_state_t;

    src_state_t       state;
    table_idx_t       tbl_idx;
    band_idx_t        band_cnt;
    logic [PIX_W-1:0] pix_cnt;

    logic last_entry;
    logic last_pixel;
    logic last_band;

    assign last_entry = (tbl_idx == table_idx_t'(INIT_LEN - 1));
    assign last_pixel = (pix_cnt == PIX_W'(PIXELS_PER_BAND - 1));
    assign last_band  = (band_cnt == band_idx_t'(NUM_BANDS - 1));

    // ==================================================
    // word selection
    // ==================================================

    // counters move on the same edge as load, so the word is valid with it
    always_comb begin
        word_bus.word = '0;
        word_bus.rs   = 1'b0;
        word_bus.wide = 1'b0;
        case (state)
            ST_BOOT, ST_CONFIG: begin
                word_bus.word = {8'h00, INIT_TABLE[tbl_idx].data};
                word_bus.rs   = INIT_TABLE[tbl_idx].rs;
            end
            ST_RAMWR: begin
                word_bus.word = {8'h00, CMD_RAMWR};  // command, rs low
            end
            ST_PIXELS: begin
                word_bus.word = band_color[band_cnt];
                word_bus.rs   = 1'b1;
                word_bus.wide = 1'b1;
            end
            default: ;
        endcase
    end

    // ==================================================
    // sequencing
    // ==================================================

    always_ff @(posedge lcd_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            state              <= ST_IDLE;
            tbl_idx            <= '0;
            band_cnt           <= '0;
            pix_cnt            <= '0;
            word_bus.load      <= 1'b0;
            phase.slpout_sent  <= 1'b0;
            phase.disp_on_sent <= 1'b0;
        end else begin
            word_bus.load      <= 1'b0;
            phase.slpout_sent  <= 1'b0;
            phase.disp_on_sent <= 1'b0;
            case (state)
                ST_IDLE: begin
                    if (phase.boot_go) begin
                        tbl_idx       <= '0;
                        state         <= ST_BOOT;
                        word_bus.load <= 1'b1;
                    end else if (phase.config_go) begin
                        tbl_idx       <= table_idx_t'(1);  // entry 0 went at boot
                        state         <= ST_CONFIG;
                        word_bus.load <= 1'b1;
                    end else if (phase.fill_go) begin
                        state         <= ST_RAMWR;
                        word_bus.load <= 1'b1;
                    end
                end
                ST_BOOT: if (word_bus.done) begin
                    phase.slpout_sent <= 1'b1;
                    state             <= ST_IDLE;
                end
                ST_CONFIG: if (word_bus.done) begin
                    if (last_entry) begin
                        phase.disp_on_sent <= 1'b1;
                        state              <= ST_IDLE;
                    end else begin
                        tbl_idx       <= tbl_idx + 1'b1;
                        word_bus.load <= 1'b1;
                    end
                end
                ST_RAMWR: if (word_bus.done) begin
                    band_cnt      <= '0;
                    pix_cnt       <= '0;
                    state         <= ST_PIXELS;
                    word_bus.load <= 1'b1;
                end
                ST_PIXELS: if (word_bus.done) begin
                    if (!last_pixel) begin
                        pix_cnt       <= pix_cnt + 1'b1;
                        word_bus.load <= 1'b1;
                    end else if (!last_band) begin
                        pix_cnt       <= '0;
                        band_cnt      <= band_cnt + 1'b1;
                        word_bus.load <= 1'b1;
                    end else begin
                        state <= ST_DONE;  // no more loads until reset
                    end
                end
                default: ;
            endcase
        end
    end

endmodule

/* rtl/spi_word_shifter.sv */
/*
 * 3-wire write-only serializer, 8 or 16 bits MSB first
 * one chip-select window per word, rs held for the word
 */
`timescale 1ns/1ns

module spi_word_shifter (
    input  logic    lcd_clk,
    input  logic    sys_rst_n,
    lcd_word_if.shf word_bus,
    output logic    lcd_scl,
    output logic    lcd_sda,
    output logic    lcd_rs,
    output logic    lcd_cs
);

    import st7735_pkg::*;

    word_t      aligned_word;  // MSB of the word at bit 15
    word_t      shreg;         // bits still to go
    logic [3:0] bit_cnt;       // bits left after the current one
    logic       last_bit;

    assign aligned_word  = word_bus.wide ? word_bus.word : {word_bus.word[7:0], 8'h00};
    assign last_bit      = (bit_cnt == '0);
    assign word_bus.done = !lcd_cs && last_bit;

    // panel samples on the rising scl edge, mid-way through each bit
    assign lcd_scl = ~lcd_clk;

    // ==================================================
    // chip select, bit counter and pins
    // ==================================================

    always_ff @(posedge lcd_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            lcd_cs  <= 1'b1;
            lcd_sda <= 1'b0;
            lcd_rs  <= 1'b0;
            bit_cnt <= '0;
        end else if (lcd_cs) begin
            if (word_bus.load) begin
                lcd_cs  <= 1'b0;
                lcd_sda <= aligned_word[15];  // first bit goes out at once
                lcd_rs  <= word_bus.rs;
                bit_cnt <= word_bus.wide ? 4'd15 : 4'd7;
            end
        end else if (last_bit) begin
            lcd_cs  <= 1'b1;  // end of window
            lcd_sda <= 1'b0;
        end else begin
            lcd_sda <= shreg[15];
            bit_cnt <= bit_cnt - 1'b1;
        end
    end

    always_ff @(posedge lcd_clk) begin
        if (lcd_cs && word_bus.load) begin
            shreg <= {aligned_word[14:0], 1'b0};
        end else if (!lcd_cs) begin
            shreg <= {shreg[14:0], 1'b0};
        end
    end

    // source must wait for done before the next word
    a_no_load_busy: assert property (
        @(posedge lcd_clk) disable iff (!sys_rst_n)
        word_bus.load |-> lcd_cs
    );

endmodule

/* rtl/st7735_fill_top.sv */
/*
 * ST7735R single-frame fill, top level
 * power sequencer, command source and serial shifter
 */
`timescale 1ns/1ns

module st7735_fill_top #(
    parameter int RST_LEAD_CYCLES    = 4096,
    parameter int RST_LOW_CYCLES     = 4096,
    parameter int RST_RECOVER_CYCLES = 4096,
    parameter int SLEEP_WAIT_CYCLES  = 65535,
    parameter int DISP_WAIT_CYCLES   = 65535,
    parameter int PIXELS_PER_BAND    = 4096
) (
    input  logic lcd_clk,
    input  logic sys_rst_n,
    output logic lcd_scl,
    output logic lcd_sda,
    output logic lcd_rs,
    output logic lcd_cs,
    output logic lcd_rst
);

    import st7735_pkg::*;

    localparam int DLY_LIMIT = 1 << DLY_W;  // longest delay the sequencer counts

    if (RST_LEAD_CYCLES < 1 || RST_LEAD_CYCLES > DLY_LIMIT ||
        RST_LOW_CYCLES < 1 || RST_LOW_CYCLES > DLY_LIMIT ||
        RST_RECOVER_CYCLES < 1 || RST_RECOVER_CYCLES > DLY_LIMIT ||
        SLEEP_WAIT_CYCLES < 1 || SLEEP_WAIT_CYCLES > DLY_LIMIT ||
        DISP_WAIT_CYCLES < 1 || DISP_WAIT_CYCLES > DLY_LIMIT ||
        PIXELS_PER_BAND < 1) begin : g_bad_param
        $error("st7735_fill_top: delay outside 1 .. %0d or empty band", DLY_LIMIT);
    end

    lcd_phase_if phase_bus ();
    lcd_word_if  word_bus ();

    panel_power_seq #(
        .RST_LEAD_CYCLES    (RST_LEAD_CYCLES),
        .RST_LOW_CYCLES     (RST_LOW_CYCLES),
        .RST_RECOVER_CYCLES (RST_RECOVER_CYCLES),
        .SLEEP_WAIT_CYCLES  (SLEEP_WAIT_CYCLES),
        .DISP_WAIT_CYCLES   (DISP_WAIT_CYCLES)
    ) u_power_seq (
        .lcd_clk   (lcd_clk),
        .sys_rst_n (sys_rst_n),
        .lcd_rst   (lcd_rst),
        .phase     (phase_bus.seq)
    );

    st7735_cmd_source #(
        .PIXELS_PER_BAND (PIXELS_PER_BAND)
    ) u_cmd_source (
        .lcd_clk   (lcd_clk),
        .sys_rst_n (sys_rst_n),
        .phase     (phase_bus.src),
        .word_bus  (word_bus.src)
    );

    spi_word_shifter u_shifter (
        .lcd_clk   (lcd_clk),
        .sys_rst_n (sys_rst_n),
        .word_bus  (word_bus.shf),
        .lcd_scl   (lcd_scl),
        .lcd_sda   (lcd_sda),
        .lcd_rs    (lcd_rs),
        .lcd_cs    (lcd_cs)
    );

endmodule

/* test/tb_expected_stream.svh */
/*
 * testbench copy of the ST7735R configuration table and colour bands
 * expected word list builder and the value check
 */
`ifndef TB_EXPECTED_STREAM_SVH
`define TB_EXPECTED_STREAM_SVH

// {rs, byte}, rs high for a data byte
localparam logic [8:0] TB_TABLE [91] = '{
    9'h011,
    9'h0b1, 9'h101, 9'h12c, 9'h12d, 9'h0b2, 9'h101, 9'h12c, 9'h12d,
    9'h0b3, 9'h101, 9'h12c, 9'h12d, 9'h101, 9'h12c, 9'h12d,
    9'h0b4, 9'h103, 9'h0b6, 9'h1b4, 9'h1f0,
    9'h0c0, 9'h1a2, 9'h102, 9'h184, 9'h0c1, 9'h1c5,
    9'h0c2, 9'h10a, 9'h100, 9'h0c3, 9'h18a, 9'h12a, 9'h0c4, 9'h18a, 9'h1ee,
    9'h0c5, 9'h10a, 9'h036, 9'h1c8,
    9'h0e0, 9'h102, 9'h11c, 9'h107, 9'h112, 9'h137, 9'h132, 9'h129, 9'h12d,
    9'h129, 9'h125, 9'h12b, 9'h139, 9'h100, 9'h101, 9'h103, 9'h110,
    9'h0e1, 9'h103, 9'h11d, 9'h107, 9'h106, 9'h12e, 9'h12c, 9'h129, 9'h12d,
    9'h12e, 9'h12e, 9'h137, 9'h13f, 9'h100, 9'h100, 9'h102, 9'h110,
    9'h02a, 9'h100, 9'h100, 9'h100, 9'h17f, 9'h02b, 9'h100, 9'h100, 9'h100, 9'h19f,
    9'h0f0, 9'h101, 9'h0f6, 9'h100, 9'h03a, 9'h105,
    9'h029
};

// red, white, green, black, blue
localparam logic [15:0] TB_BANDS [5] = '{16'hf800, 16'hffff, 16'h07e0, 16'h0000, 16'h001f};

// key as hex reads rs, bit count, data
function automatic word_key_t make_key(logic rs, int nbits, logic [15:0] data);
    return {3'b000, rs, 8'(nbits), data};
endfunction

function automatic void build_expected(output word_key_t q[$]);
    for (int i = 0; i < 91; i++) begin
        q.push_back(make_key(TB_TABLE[i][8], 8, {8'h00, TB_TABLE[i][7:0]}));
    end
    q.push_back(make_key(1'b0, 8, 16'h002c));  // memory write
    for (int b = 0; b < 5; b++) begin
        for (int p = 0; p < PIX_PER_BAND; p++) begin
            q.push_back(make_key(1'b1, 16, TB_BANDS[b]));
        end
    end
endfunction

task automatic check_value(string name, word_key_t expected, word_key_t actual);
    if (expected !== actual) begin
        $display("Fail %s expected %h actual %h", name, expected, actual);
        err_cnt++;
    end
endtask

`endif

/* test/tb_st7735_fill.sv */
/*
 * testbench for the ST7735R fill design
 * clock, reset, serial receiver, reference stream compare, restart
 */
`timescale 1ns/1ns

module tb_st7735_fill;

    localparam int LEAD         = 8;
    localparam int LOW          = 10;
    localparam int RECOVER      = 6;
    localparam int SLEEP        = 40;
    localparam int DISP         = 30;
    localparam int PIX_PER_BAND = 4;
    localparam int NUM_WORDS    = 91 + 1 + 5 * PIX_PER_BAND;
    localparam int WAIT_LIMIT   = 5000;  // cycles per wait

    typedef logic [27:0] word_key_t;

    logic lcd_clk, sys_rst_n;
    logic lcd_scl, lcd_sda, lcd_rs, lcd_cs, lcd_rst;

    int        cyc, err_cnt, test_cnt, test_fail, cmp_idx, rst_low_cnt, rs_glitch, scl_bad;
    int        rx_bits, rx_first, rx_last;
    logic      rx_rs;
    logic [15:0] rx_data;
    bit        timed_out;
    string     run_tag;
    word_key_t rx_q[$], exp_q[$];
    int        word_start[$], word_end[$];

    `include "tb_expected_stream.svh"

    st7735_fill_top #(
        .RST_LEAD_CYCLES    (LEAD),
        .RST_LOW_CYCLES     (LOW),
        .RST_RECOVER_CYCLES (RECOVER),
        .SLEEP_WAIT_CYCLES  (SLEEP),
        .DISP_WAIT_CYCLES   (DISP),
        .PIXELS_PER_BAND    (PIX_PER_BAND)
    ) dut_i (
        .lcd_clk   (lcd_clk),
        .sys_rst_n (sys_rst_n),
        .lcd_scl   (lcd_scl),
        .lcd_sda   (lcd_sda),
        .lcd_rs    (lcd_rs),
        .lcd_cs    (lcd_cs),
        .lcd_rst   (lcd_rst)
    );

    always #2 lcd_clk = ~lcd_clk;
    always @(posedge lcd_clk) cyc++;
    always @(negedge lcd_clk) if (!lcd_rst) rst_low_cnt++;  // panel reset low cycles

    // ==================================================
    // panel receiver model with one word per cs window
    // ==================================================

    always @(posedge lcd_scl) begin
        if (lcd_clk !== 1'b0) scl_bad++;  // scl rises mid-way through the bit
        if (!sys_rst_n) begin
            rx_bits = 0;
        end else if (!lcd_cs) begin
            if (rx_bits == 0) begin
                rx_rs    = lcd_rs;
                rx_data  = '0;
                rx_first = cyc;
            end
            if (lcd_rs !== rx_rs) rs_glitch++;
            rx_data = {rx_data[14:0], lcd_sda};  // msb first
            rx_bits++;
            rx_last = cyc;
        end else if (rx_bits != 0) begin
            rx_q.push_back(make_key(rx_rs, rx_bits, rx_data));
            word_start.push_back(rx_first);
            word_end.push_back(rx_last);
            rx_bits = 0;
        end
    end

    function automatic string stage_name(int idx);
        if (idx == 0) return {run_tag, " sleep_out"};
        if (idx < 91) return {run_tag, " config"};
        if (idx == 91) return {run_tag, " ramwr"};
        return {run_tag, " fill"};
    endfunction

    always @(posedge lcd_clk) begin : compare_words
        word_key_t got;
        while (rx_q.size() > 0) begin
            got = rx_q.pop_front();
            if (cmp_idx < exp_q.size()) begin
                check_value(stage_name(cmp_idx), exp_q[cmp_idx], got);
            end else begin
                report_error($sformatf("unexpected word %h after the end of the frame", got));
            end
            cmp_idx++;
        end
    end

    // ==================================================
    // helpers
    // ==================================================

    task automatic report_error(string msg);
        $display("Error: %s", msg);
        err_cnt++;
    endtask

    task automatic end_test(string name, int err_before);
        test_cnt++;
        if (err_cnt == err_before) begin
            $display("test %s %s: passed", run_tag, name);
        end else begin
            test_fail++;
            $display("test %s %s: %0d error(s)", run_tag, name, err_cnt - err_before);
        end
    endtask

    task automatic apply_reset();
        @(negedge lcd_clk);
        sys_rst_n = 1'b0;
        repeat (2) @(negedge lcd_clk);
        rx_q.delete();  // receiver starts clean
        word_start.delete();
        word_end.delete();
        rx_bits     = 0;
        cmp_idx     = 0;
        rst_low_cnt = 0;
        rs_glitch   = 0;
        scl_bad     = 0;
        sys_rst_n   = 1'b1;
    endtask

    task automatic wait_words(int n, string what);
        int waited;
        waited = 0;
        while (cmp_idx < n && waited < WAIT_LIMIT) begin
            @(negedge lcd_clk);
            waited++;
        end
        if (cmp_idx < n) begin
            report_error($sformatf("timeout waiting for %s, only %0d words arrived", what, cmp_idx));
            timed_out = 1'b1;
        end
    endtask

    task automatic check_gap(int idx, int min_idle, string what);
        int idle;
        idle = word_start[idx + 1] - word_end[idx] - 1;
        if (idle < min_idle) begin
            report_error($sformatf("chip select idle only %0d cycles after %s, %0d needed",
                                   idle, what, min_idle));
        end
    endtask

    // ==================================================
    // behaviours
    // ==================================================

    task automatic check_reset_pulse();
        int  t_rel, t_fall, t_rise, n;
        bit  cs_low;
        t_rel  = cyc;
        n      = 0;
        cs_low = 1'b0;
        while (lcd_rst === 1'b1 && n < 200) begin
            if (lcd_cs !== 1'b1) cs_low = 1'b1;
            @(negedge lcd_clk);
            n++;
        end
        t_fall = cyc;
        while (lcd_rst === 1'b0 && n < 200) begin
            if (lcd_cs !== 1'b1) cs_low = 1'b1;
            @(negedge lcd_clk);
            n++;
        end
        t_rise = cyc;
        if (n >= 200) begin
            report_error("timeout waiting for the panel reset pulse");
            timed_out = 1'b1;
            return;
        end
        check_value({run_tag, " rst lead cycles"}, 28'(LEAD), 28'(t_fall - t_rel));
        check_value({run_tag, " rst low cycles"}, 28'(LOW), 28'(t_rise - t_fall));
        if (cs_low) report_error("chip select went low during the panel reset pulse");
    endtask

    task automatic check_idle();
        bit cs_low;
        cs_low = 1'b0;
        for (int i = 0; i < 200; i++) begin
            @(negedge lcd_clk);
            if (lcd_cs !== 1'b1) cs_low = 1'b1;
        end
        if (cs_low) report_error("chip select went low after the last pixel");
        if (rs_glitch != 0) report_error("lcd_rs changed inside a chip-select window");
        if (scl_bad != 0) report_error("lcd_scl rose while lcd_clk was high");
        check_value({run_tag, " word count"}, 28'(NUM_WORDS), 28'(word_end.size()));
        check_value({run_tag, " rst low total"}, 28'(LOW), 28'(rst_low_cnt));
    endtask

    task automatic run_frame();
        int e;
        e = err_cnt;
        check_reset_pulse();
        end_test("reset_pulse", e);
        if (timed_out) return;
        e = err_cnt;
        wait_words(2, "the first config word");
        if (!timed_out) check_gap(0, SLEEP, "sleep-out");
        end_test("sleep_out", e);
        if (timed_out) return;
        e = err_cnt;
        wait_words(92, "the memory-write command");
        if (!timed_out) check_gap(90, DISP, "display-on");
        end_test("config_stream", e);
        if (timed_out) return;
        e = err_cnt;
        wait_words(NUM_WORDS, "the last pixel");
        end_test("fill", e);
        if (timed_out) return;
        e = err_cnt;
        check_idle();
        end_test("idle_after_frame", e);
    endtask

    task automatic restart_mid_stream();
        int e, delay;
        e = err_cnt;
        apply_reset();
        delay = $urandom_range(1200, 30);  // somewhere between boot and the last band
        repeat (delay) @(negedge lcd_clk);
        sys_rst_n = 1'b0;
        @(negedge lcd_clk);
        check_value("restart lcd_rst", 28'(1), 28'(lcd_rst));
        check_value("restart lcd_cs", 28'(1), 28'(lcd_cs));
        check_value("restart lcd_sda", 28'(0), 28'(lcd_sda));
        check_value("restart lcd_rs", 28'(0), 28'(lcd_rs));
        end_test("reset_mid_stream", e);
        apply_reset();
    endtask

    initial begin
        lcd_clk   = 1'b0;
        sys_rst_n = 1'b0;
        cyc       = 0;
        err_cnt   = 0;
        test_cnt  = 0;
        test_fail = 0;
        timed_out = 1'b0;
        void'($urandom(95));
        build_expected(exp_q);
        run_tag = "first";
        apply_reset();
        run_frame();
        if (!timed_out) begin
            run_tag = "restart";
            restart_mid_stream();
            run_frame();
        end
        $display("summary: %0d tests, %0d failed, %0d errors", test_cnt, test_fail, err_cnt);
        if (err_cnt == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

/* sim.f */
+incdir+include
+incdir+test
rtl/st7735_pkg.sv
rtl/lcd_word_if.sv
rtl/lcd_phase_if.sv
rtl/panel_power_seq.sv
rtl/st7735_cmd_source.sv
rtl/spi_word_shifter.sv
rtl/st7735_fill_top.sv
test/tb_st7735_fill.sv

/* run_sim.sh */
#!/bin/sh
# compile and run the ST7735R fill testbench with Verilator
set -e
cd "$(dirname "$0")"
rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal -f sim.f --top-module tb_st7735_fill -o sim_tb
status=0
./obj_dir/sim_tb > sim.log 2>&1 || status=$?
cat sim.log
if [ "$status" -ne 0 ] || grep -q "CHECKS FAILED" sim.log; then
    echo "simulation reported failure"
    exit 1
fi
if ! grep -q "ALL CHECKS PASSED" sim.log; then
    echo "simulation ended without a result"
    exit 1
fi
echo "simulation ok"
